// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_unit
FLIST     ?= flist.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_STR  ?= TEST PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/axi_imem_model.sv
module axi_imem_model #(
    parameter logic [31:0] seed_init  = 32'h1,
    parameter logic [31:0] data_key   = 32'ha5a5_0000,
    parameter logic [31:0] err_addr_a = 32'hffff_fff0,
    parameter logic [31:0] err_addr_b = 32'hffff_fff0,
    parameter int          max_pend   = 8
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [axi_lite_pkg::addr_w-1:0] araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [axi_lite_pkg::data_w-1:0] rdata,
    output logic [axi_lite_pkg::resp_w-1:0] rresp,
    output logic                            rvalid,
    input  logic                            rready
);

    import axi_lite_pkg::*;

    localparam logic [resp_w-1:0] resp_slverr = 2'b10;

    logic [addr_w-1:0] pend_q [$];  // accepted reads, oldest first
    logic [addr_w-1:0] addr;
    integer            seed;
    logic              in_rst;
    logic              ar_hs;
    logic              r_hs;

    initial begin
        seed    = seed_init;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = resp_okay;
    end

    always @(posedge clk) begin
        in_rst = !rstn;     // sampled at the edge like the DUT
        ar_hs  = arvalid && arready;
        r_hs   = rvalid && rready;
        if (in_rst) begin
            pend_q.delete();
        end else if (ar_hs) begin
            pend_q.push_back(araddr);
        end
        #1;
        if (in_rst) begin
            arready = 1'b0;
            rvalid  = 1'b0;
        end else begin
            arready = (pend_q.size() < max_pend) && (($random(seed) & 3) != 0);
            if (r_hs || !rvalid) begin
                // beat held until rready, otherwise maybe start the next one
                if (pend_q.size() > 0 && (($random(seed) & 3) != 0)) begin
                    addr   = pend_q.pop_front();
                    rvalid = 1'b1;
                    rdata  = addr ^ data_key;
                    rresp  = (addr == err_addr_a || addr == err_addr_b) ? resp_slverr
                                                                        : resp_okay;
                end else begin
                    rvalid = 1'b0;
                end
            end
        end
    end

endmodule

// File: dv/fetch_unit_checker.sv
module fetch_unit_checker (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [axi_lite_pkg::addr_w-1:0] araddr,
    input  logic                            arvalid,
    input  logic                            arready,
    input  logic                            out_valid,
    input  logic                            out_ready,
    input  logic                            br_taken,
    input  logic                            ex_en,
    input  logic                            ertn_flush
);

    int   assert_fails = 0;
    logic rst_q;        // reset seen at the previous edge
    logic redirect;

    assign redirect = br_taken | ex_en | ertn_flush;

    always_ff @(posedge clk) begin
        rst_q <= !rstn;
    end

    ar_held: assert property (@(posedge clk) disable iff (!rstn)
        arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
        $error("AR request changed or withdrawn before arready");
        assert_fails++;
    end

    // also covers the first edge after release
    ar_quiet_in_reset: assert property (@(posedge clk) rst_q |-> !arvalid)
    else begin
        $error("arvalid high during reset");
        assert_fails++;
    end

    out_held: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready && !redirect |=> out_valid)
    else begin
        $error("out_valid dropped without a handshake or redirect");
        assert_fails++;
    end

endmodule

// File: dv/tb_fetch_unit.sv
module tb_fetch_unit;

    import cpu_pkg::*;

    localparam logic [31:0] reset_pc   = 32'h1c00_0000;
    localparam logic [31:0] data_key   = 32'ha5a5_0000;
    localparam logic [31:0] err_addr_a = 32'h1c00_0020;    // inside the straight run
    localparam logic [31:0] err_addr_b = 32'h1c00_5010;
    localparam int seq_pkts     = 40;
    localparam int bp_pkts      = 40;
    localparam int redirect_cnt = 30;
    localparam int resume_pkts  = 8;
    localparam int quiet_cycles = 20;
    // old fetches drain before the one-bit epoch comes round again
    localparam int min_gap      = 12;
    localparam int max_gap      = 8;
    localparam int cycle_limit  = 16 * (seq_pkts + bp_pkts + 4 * resume_pkts)
                                  + redirect_cnt * (min_gap + max_gap + 2)
                                  + quiet_cycles + 200;
    localparam int kind_any = 0;
    localparam int kind_ex  = 1;
    localparam int kind_err = 2;

    logic            clk = 1'b0;
    logic            rstn;
    logic            br_taken;
    logic [xlen-1:0] br_target;
    logic            ex_en;
    logic [xlen-1:0] ex_entry_pc;
    logic            ertn_flush;
    logic [xlen-1:0] era_pc;
    logic [31:0]     araddr;
    logic [2:0]      arprot;
    logic            arvalid;
    logic            arready;
    logic [31:0]     rdata;
    logic [1:0]      rresp;
    logic            rvalid;
    logic            rready;
    logic            out_valid;
    logic            out_ready;
    logic [xlen-1:0] out_pc;
    logic [xlen-1:0] out_inst;
    logic            out_ex;
    logic [7:0]      out_ecode;
    logic            out_esubcode;
    logic            out_bus_err;

    integer          seed;
    logic            bp_on = 1'b0;
    logic [xlen-1:0] exp_pc = reset_pc;
    logic            halted = 1'b0;  // model saw an ADEF packet
    int              pkt_cnt = 0;
    int              ex_cnt = 0;
    int              err_cnt = 0;
    int              check_cnt = 0;
    int              error_cnt = 0;
    int              cycle_cnt = 0;
    int              test_no = 0;
    int              mark = 0;
    int              total;

    always #5 clk = ~clk;

    fetch_unit #(
        .reset_pc   (reset_pc),
        .meta_depth (4),
        .out_depth  (2)
    ) u_dut (.*);

    axi_imem_model #(
        .seed_init  (32'h323e7db0),
        .data_key   (data_key),
        .err_addr_a (err_addr_a),
        .err_addr_b (err_addr_b)
    ) u_mem (
        .clk     (clk),
        .rstn    (rstn),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    bind fetch_unit fetch_unit_checker u_checker (
        .clk        (clk),
        .rstn       (rstn),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .br_taken   (br_taken),
        .ex_en      (ex_en),
        .ertn_flush (ertn_flush)
    );

    function automatic inst_pkt_t expected_pkt(input logic [xlen-1:0] pc);
        inst_pkt_t p;
        p    = '0;
        p.pc = pc;
        if (pc[1:0] != 2'b00) begin
            p.ex    = 1'b1;
            p.ecode = 8'h08;
        end else begin
            p.inst    = pc ^ data_key;
            p.bus_err = (pc == err_addr_a) || (pc == err_addr_b);
        end
        return p;
    endfunction

    task automatic check_pkt(input inst_pkt_t got, input inst_pkt_t want);
        logic ok;
        ok = (got.pc == want.pc) && (got.ex == want.ex) && (got.ecode == want.ecode)
             && (got.esubcode == want.esubcode) && (got.bus_err == want.bus_err)
             && (want.ex || got.inst == want.inst);   // no data behind an ADEF
        check_cnt++;
        if (!ok) begin
            error_cnt++;
            $display("CHECK FAILED t=%0t got/exp pc %h/%h inst %h/%h ex %b/%b ec %h/%h be %b/%b",
                     $time, got.pc, want.pc, got.inst, want.inst, got.ex, want.ex,
                     got.ecode, want.ecode, got.bus_err, want.bus_err);
        end
    endtask

    task automatic check_quiet(input logic valid);
        check_cnt++;
        if (valid) begin
            error_cnt++;
            $display("CHECK FAILED t=%0t out_valid high while fetch waits for a redirect",
                     $time);
        end
    endtask

    // arprot[2] set marks an instruction access
    task automatic check_prot(input logic [axi_lite_pkg::prot_w-1:0] got);
        check_cnt++;
        if (got[2] !== 1'b1) begin
            error_cnt++;
            $display("CHECK FAILED t=%0t arprot %b does not mark an instruction fetch",
                     $time, got);
        end
    endtask

    // reference model, sampled at the edge
    always @(posedge clk) begin
        inst_pkt_t got;
        inst_pkt_t want;
        if (rstn) begin
            if (arvalid) begin
                check_prot(arprot);
            end
            if (halted) begin
                check_quiet(out_valid);
            end else if (out_valid && out_ready) begin
                got.pc       = out_pc;
                got.inst     = out_inst;
                got.ex       = out_ex;
                got.ecode    = out_ecode;
                got.esubcode = out_esubcode;
                got.bus_err  = out_bus_err;
                want         = expected_pkt(exp_pc);
                check_pkt(got, want);
                pkt_cnt++;
                if (want.bus_err) begin
                    err_cnt++;
                end
                if (want.ex) begin
                    ex_cnt++;
                    halted = 1'b1;
                end else begin
                    exp_pc = exp_pc + 32'd4;
                end
            end
            if (ex_en) begin   // exception entry wins, then ertn, then branch
                exp_pc = ex_entry_pc;
            end else if (ertn_flush) begin
                exp_pc = era_pc;
            end else if (br_taken) begin
                exp_pc = br_target;
            end
            if (ex_en || ertn_flush || br_taken) begin
                halted = 1'b0;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
        br_taken   = 1'b0;
        ex_en      = 1'b0;
        ertn_flush = 1'b0;
        out_ready  = bp_on ? (($random(seed) & 1) != 0) : 1'b1;
    endtask

    function automatic int tally(input int kind);
        case (kind)
            kind_ex:  return ex_cnt;
            kind_err: return err_cnt;
            default:  return pkt_cnt;
        endcase
    endfunction

    task automatic await_pkts(input int kind, input int n);
        int target;
        target = tally(kind) + n;
        while (tally(kind) < target) begin
            next_cycle();
        end
    endtask

    task automatic send_redirect(input logic br, input logic [xlen-1:0] br_pc,
                                 input logic ex, input logic [xlen-1:0] ex_pc,
                                 input logic ertn, input logic [xlen-1:0] ertn_pc);
        br_taken    = br;
        br_target   = br_pc;
        ex_en       = ex;
        ex_entry_pc = ex_pc;
        ertn_flush  = ertn;
        era_pc      = ertn_pc;
        next_cycle();
    endtask

    function automatic logic [xlen-1:0] rand_target();
        return {20'h1c001, 10'($random(seed)), 2'b00};
    endfunction

    task automatic random_redirect();
        logic [2:0] sel;
        sel = 3'($random(seed));
        if (sel == 3'b000) begin
            sel = 3'b001;
        end
        send_redirect(sel[0], rand_target(), sel[1], rand_target(), sel[2], rand_target());
    endtask

    task automatic end_test(input string name);
        test_no++;
        $display("test %0d %s: %s at t=%0t", test_no, name,
                 (error_cnt == mark) ? "ok" : "errors", $time);
        mark = error_cnt;
    endtask

    initial begin
        seed        = 32'h323e7db0;
        rstn        = 1'b0;
        br_taken    = 1'b0;
        br_target   = '0;
        ex_en       = 1'b0;
        ex_entry_pc = '0;
        ertn_flush  = 1'b0;
        era_pc      = '0;
        out_ready   = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rstn      = 1'b1;
        out_ready = 1'b1;

        await_pkts(kind_any, seq_pkts);
        end_test("sequential fetch");

        bp_on = 1'b1;
        await_pkts(kind_any, bp_pkts);
        end_test("decode back-pressure");

        for (int i = 0; i < redirect_cnt; i++) begin
            repeat (min_gap + ($random(seed) & (max_gap - 1))) next_cycle();
            random_redirect();
        end
        await_pkts(kind_any, resume_pkts);
        end_test("random redirects");

        send_redirect(1'b1, 32'h1c00_3002, 1'b0, '0, 1'b0, '0);
        await_pkts(kind_ex, 1);
        repeat (quiet_cycles) next_cycle();
        send_redirect(1'b0, '0, 1'b1, 32'h1c00_3100, 1'b0, '0);
        await_pkts(kind_any, resume_pkts);
        end_test("misaligned target");

        send_redirect(1'b0, '0, 1'b0, '0, 1'b1, err_addr_b - 32'd8);
        await_pkts(kind_err, 1);
        await_pkts(kind_any, resume_pkts);
        end_test("slave error response");

        total = error_cnt + u_dut.u_checker.assert_fails;
        $display("tests %0d, packets %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_no, pkt_cnt, check_cnt, error_cnt, u_dut.u_checker.assert_fails);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        wait (rstn === 1'b1);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: tests did not finish within %0d cycles", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: flist.f
logic/cpu_pkg.sv
logic/axi_lite_pkg.sv
logic/fetch_queue.sv
logic/pc_gen.sv
logic/inst_assembler.sv
logic/fetch_unit.sv
dv/axi_imem_model.sv
dv/fetch_unit_checker.sv
dv/tb_fetch_unit.sv

// File: logic/axi_lite_pkg.sv
package axi_lite_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int resp_w = 2;
    localparam int prot_w = 3;

    localparam logic [resp_w-1:0] resp_okay = 2'b00;

    // arprot[2] set marks an instruction access
    localparam logic [prot_w-1:0] prot_inst = 3'b100;

endpackage

// File: logic/cpu_pkg.sv
package cpu_pkg;

    // machine word, also the fetch address width
    localparam int xlen = 32;

    // address error on fetch
    localparam logic [7:0] ecode_adef    = 8'h08;
    localparam logic       esubcode_adef = 1'b0;

    // one fetch in flight, queued between pc_gen and the assembler
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic            epoch;     // redirect generation it was issued under
        logic            ex;        // no read issued for this entry
        logic [7:0]      ecode;
        logic            esubcode;
    } fetch_meta_t;

    // packet handed to decode
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        logic            ex;
        logic [7:0]      ecode;
        logic            esubcode;
        logic            bus_err;   // response was not OKAY
    } inst_pkt_t;

endpackage

// File: logic/fetch_queue.sv
module fetch_queue #(
    parameter type entry_t = logic [31:0],
    parameter int  depth   = 2
) (
    input  logic   clk,
    input  logic   rstn,
    input  logic   flush,
    input  logic   push,
    input  entry_t push_data,
    input  logic   pop,
    output entry_t head,
    output logic   empty,
    output logic   full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    entry_t           mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wraps at depth, works for any depth
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == cnt_w'(depth));
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin   // drops whatever is pushed this cycle too
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// File: logic/fetch_unit.sv
module fetch_unit #(
    parameter logic [cpu_pkg::xlen-1:0] reset_pc   = 32'h1c00_0000,
    parameter int                       meta_depth = 4,
    parameter int                       out_depth  = 2
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            br_taken,
    input  logic [cpu_pkg::xlen-1:0]        br_target,
    input  logic                            ex_en,
    input  logic [cpu_pkg::xlen-1:0]        ex_entry_pc,
    input  logic                            ertn_flush,
    input  logic [cpu_pkg::xlen-1:0]        era_pc,
    output logic [axi_lite_pkg::addr_w-1:0] araddr,
    output logic [axi_lite_pkg::prot_w-1:0] arprot,
    output logic                            arvalid,
    input  logic                            arready,
    input  logic [axi_lite_pkg::data_w-1:0] rdata,
    input  logic [axi_lite_pkg::resp_w-1:0] rresp,
    input  logic                            rvalid,
    output logic                            rready,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic [cpu_pkg::xlen-1:0]        out_pc,
    output logic [cpu_pkg::xlen-1:0]        out_inst,
    output logic                            out_ex,
    output logic [7:0]                      out_ecode,
    output logic                            out_esubcode,
    output logic                            out_bus_err
);

    import cpu_pkg::*;

    fetch_meta_t meta_push_data;
    fetch_meta_t meta_head;
    logic        meta_push;
    logic        meta_full;
    logic        meta_empty;
    logic        meta_pop;
    logic        cur_epoch;
    inst_pkt_t   pkt_push_data;
    inst_pkt_t   pkt_head;
    logic        pkt_push;
    logic        pkt_full;
    logic        pkt_empty;
    logic        pkt_pop;
    logic        redirect;

    assign redirect = ex_en | ertn_flush | br_taken;

    pc_gen #(
        .reset_pc (reset_pc)
    ) u_pc_gen (
        .clk         (clk),
        .rstn        (rstn),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .ex_en       (ex_en),
        .ex_entry_pc (ex_entry_pc),
        .ertn_flush  (ertn_flush),
        .era_pc      (era_pc),
        .araddr      (araddr),
        .arprot      (arprot),
        .arvalid     (arvalid),
        .arready     (arready),
        .push        (meta_push),
        .push_data   (meta_push_data),
        .meta_full   (meta_full),
        .cur_epoch   (cur_epoch)
    );

    // read details, stale ones are sorted out by epoch
    fetch_queue #(
        .entry_t (fetch_meta_t),
        .depth   (meta_depth)
    ) u_meta_q (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (1'b0),
        .push      (meta_push),
        .push_data (meta_push_data),
        .pop       (meta_pop),
        .head      (meta_head),
        .empty     (meta_empty),
        .full      (meta_full)
    );

    inst_assembler u_asm (
        .clk        (clk),
        .rstn       (rstn),
        .cur_epoch  (cur_epoch),
        .meta_head  (meta_head),
        .meta_empty (meta_empty),
        .meta_pop   (meta_pop),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .out_push   (pkt_push),
        .out_data   (pkt_push_data),
        .out_full   (pkt_full)
    );

    fetch_queue #(
        .entry_t (inst_pkt_t),
        .depth   (out_depth)
    ) u_out_q (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (redirect),
        .push      (pkt_push),
        .push_data (pkt_push_data),
        .pop       (pkt_pop),
        .head      (pkt_head),
        .empty     (pkt_empty),
        .full      (pkt_full)
    );

    assign out_valid    = ~pkt_empty;
    assign pkt_pop      = out_valid & out_ready;
    assign out_pc       = pkt_head.pc;
    assign out_inst     = pkt_head.inst;
    assign out_ex       = pkt_head.ex;
    assign out_ecode    = pkt_head.ecode;
    assign out_esubcode = pkt_head.esubcode;
    assign out_bus_err  = pkt_head.bus_err;

endmodule

// File: logic/inst_assembler.sv
module inst_assembler (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            cur_epoch,
    input  cpu_pkg::fetch_meta_t            meta_head,
    input  logic                            meta_empty,
    output logic                            meta_pop,
    input  logic [axi_lite_pkg::data_w-1:0] rdata,
    input  logic [axi_lite_pkg::resp_w-1:0] rresp,
    input  logic                            rvalid,
    output logic                            rready,
    output logic                            out_push,
    output cpu_pkg::inst_pkt_t              out_data,
    input  logic                            out_full
);

    import axi_lite_pkg::*;

    localparam int cnt_w = 3;

    logic [cnt_w-1:0] stale_cnt;    // dropped heads whose beat is still out
    logic             head_vld;
    logic             head_stale;
    logic             head_live;
    logic             owed;
    logic             r_hs;
    logic             beat_for_head;
    logic             drop_beat;
    logic             cnt_room;
    logic             cnt_inc;
    logic             ex_emit;
    logic             inst_emit;
    logic             stale_pop;

    assign head_vld   = ~meta_empty;
    assign head_stale = head_vld & (meta_head.epoch != cur_epoch);
    assign head_live  = head_vld & ~head_stale;
    assign owed       = (stale_cnt != '0);

    // beats owed to dropped heads come first, R is in order
    assign rready = owed | (head_vld & ~meta_head.ex & (head_stale | ~out_full));

    assign r_hs          = rvalid & rready;
    assign drop_beat     = r_hs & owed;
    assign beat_for_head = r_hs & ~owed;

    assign ex_emit   = head_live & meta_head.ex & ~out_full;
    assign inst_emit = head_live & ~meta_head.ex & beat_for_head;

    // stale heads leave at once, their beat is counted if not here yet
    assign cnt_room  = (stale_cnt != '1) | drop_beat;
    assign stale_pop = head_stale & (meta_head.ex | beat_for_head | cnt_room);
    assign cnt_inc   = stale_pop & ~meta_head.ex & ~beat_for_head;

    assign meta_pop = ex_emit | inst_emit | stale_pop;
    assign out_push = ex_emit | inst_emit;

    always_comb begin
        out_data.pc       = meta_head.pc;
        out_data.inst     = meta_head.ex ? '0 : rdata;
        out_data.ex       = meta_head.ex;
        out_data.ecode    = meta_head.ecode;
        out_data.esubcode = meta_head.esubcode;
        out_data.bus_err  = ~meta_head.ex & (rresp != resp_okay);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            stale_cnt <= '0;
        end else if (cnt_inc && !drop_beat) begin
            stale_cnt <= stale_cnt + 1'b1;
        end else if (drop_beat && !cnt_inc) begin
            stale_cnt <= stale_cnt - 1'b1;
        end
    end

endmodule

// File: logic/pc_gen.sv
module pc_gen #(
    parameter logic [cpu_pkg::xlen-1:0] reset_pc = 32'h1c00_0000
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            br_taken,
    input  logic [cpu_pkg::xlen-1:0]        br_target,
    input  logic                            ex_en,
    input  logic [cpu_pkg::xlen-1:0]        ex_entry_pc,
    input  logic                            ertn_flush,
    input  logic [cpu_pkg::xlen-1:0]        era_pc,
    output logic [axi_lite_pkg::addr_w-1:0] araddr,
    output logic [axi_lite_pkg::prot_w-1:0] arprot,
    output logic                            arvalid,
    input  logic                            arready,
    output logic                            push,
    output cpu_pkg::fetch_meta_t            push_data,
    input  logic                            meta_full,
    output logic                            cur_epoch
);

    import cpu_pkg::*;
    import axi_lite_pkg::*;

    logic            redirect;
    logic [xlen-1:0] redirect_pc;
    logic [xlen-1:0] load_pc;
    logic [xlen-1:0] nxt_pc_q;      // address of the request after the current one
    logic [xlen-1:0] req_pc_q;
    logic            req_valid_q;
    logic            req_stale_q;   // redirected while its AR was waiting
    logic            req_ex;
    logic            epoch_q;
    logic            halted_q;
    logic            ar_hs;
    logic            hold;
    logic            load;

    assign redirect    = ex_en | ertn_flush | br_taken;
    assign redirect_pc = ex_en      ? ex_entry_pc :
                         ertn_flush ? era_pc      : br_target;
    assign load_pc     = redirect ? redirect_pc : nxt_pc_q;

    assign req_ex = |req_pc_q[1:0];

    // meta_full cannot rise while arvalid is up, only our own push fills it
    assign arvalid = req_valid_q & ~req_ex & ~meta_full;
    assign araddr  = req_pc_q;
    assign arprot  = prot_inst;
    assign ar_hs   = arvalid & arready;
    assign hold    = arvalid & ~arready;

    // ADEF entry goes in without a read
    assign push = ar_hs | (req_valid_q & req_ex & ~meta_full);

    assign load = redirect | (push & ~req_ex) | (~req_valid_q & ~halted_q);

    always_comb begin
        push_data.pc       = req_pc_q;
        // a request overtaken by a redirect must look stale to the assembler
        push_data.epoch    = epoch_q ^ (req_stale_q & ~redirect);
        push_data.ex       = req_ex;
        push_data.ecode    = req_ex ? ecode_adef : '0;
        push_data.esubcode = req_ex ? esubcode_adef : 1'b0;
    end

    assign cur_epoch = epoch_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            nxt_pc_q    <= reset_pc;
            req_valid_q <= 1'b0;
            req_stale_q <= 1'b0;
            epoch_q     <= 1'b0;
            halted_q    <= 1'b0;
        end else begin
            if (redirect) begin
                epoch_q  <= ~epoch_q;
                halted_q <= 1'b0;
            end else if (push && req_ex) begin
                halted_q <= 1'b1;   // wait for a redirect
            end

            if (hold) begin
                // AR stays as presented, target waits behind it
                if (redirect) begin
                    nxt_pc_q    <= redirect_pc;
                    req_stale_q <= 1'b1;
                end
            end else if (load) begin
                req_valid_q <= 1'b1;
                req_stale_q <= 1'b0;
                nxt_pc_q    <= load_pc + 32'd4;
            end else if (push) begin
                req_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold && load) begin
            req_pc_q <= load_pc;
        end
    end

endmodule
